// ==== Makefile ====
SIM      = verilator
FLAGS    = --binary --timing --assert --timescale 1ns/1ns
TOP      = executeStageTb
FILELIST = bitAlu.f
OBJDIR   = obj_dir
PASSMSG  = No errors

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

test:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJDIR)
	@out="$$(./$(OBJDIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -qx "$(PASSMSG)"

clean:
	rm -rf $(OBJDIR)

// ==== bitAlu.f ====
logic/bitAluPkg.sv
logic/aluDecoder.sv
logic/aluCore.sv
logic/zbbUnit.sv
logic/clmulUnit.sv
logic/bitManipAlu.sv
logic/executeStage.sv
dv/executeStageTb.sv

// ==== dv/executeStageTb.sv ====
//////////////////////////////////////////////////////////////////////
// Execute stage testbench
// Directed base, Zba/Zbs, Zbb, Zbc and timing tests against an
// ISA-level reference model, LCG operands and a watchdog
//////////////////////////////////////////////////////////////////////
`timescale 1ns/1ns
`default_nettype none

module executeStageTb;

  localparam int ClkPeriod   = 40;
  localparam int ResetCycles = 4;
  localparam int RandPerOp   = 8;            // Random pairs per operation
  localparam int PerSweep    = 16 + RandPerOp; // Corner pairs plus random
  localparam int NumOps      = 37;
  localparam int BurstLen    = NumOps;       // Burst covers every op once
  // Directed sweeps and burst plus both resets and a margin
  localparam int TimeoutNs   =
    (2 * NumOps * PerSweep + BurstLen + 2 * ResetCycles + 4 + 100) * ClkPeriod;

  logic                   clk;
  logic                   rst;
  logic                   valid;
  bitAluPkg::aluOp_e      op;
  logic [31:0]            a;
  logic [31:0]            b;
  logic [31:0]            result;
  logic                   resultValid;

  int          errorCount = 0;
  int          checkCount = 0;
  logic [31:0] lcgState   = 32'h7ddb;

  executeStage i_dut (
    .clk, .rst, .valid, .op, .a, .b, .result, .resultValid
  );

  initial begin
    clk = 1'b0;
    forever #(ClkPeriod / 2) clk = ~clk;
  end

  ////////////////////////////////////////////////////////////////////
  // Stimulus helpers
  ////////////////////////////////////////////////////////////////////
  function automatic logic [31:0] nextRandom();
    lcgState = lcgState * 32'd1664525 + 32'd1013904223;  // Numerical Recipes LCG
    return lcgState;
  endfunction

  function automatic logic [31:0] cornerValue(input int idx);
    case (idx)
      0:       return 32'h0000_0000;
      1:       return 32'hffff_ffff;
      2:       return 32'h8000_0000;
      default: return 32'h0000_0001;
    endcase
  endfunction

  // Reference model straight from the ISA text
  function automatic logic [31:0] refResult(input bitAluPkg::aluOp_e opSel,
                                            input logic [31:0] x, input logic [31:0] y);
    logic [31:0] r;
    logic [63:0] prod;                       // Full carry-less product
    int          sh;
    int          i;
    int          lead;
    int          trail;
    int          ones;
    sh    = int'(y[4:0]);
    prod  = '0;
    lead  = 0;
    trail = 0;
    ones  = 0;
    for (i = 0; i < 32; i++) begin
      if (y[i]) prod = prod ^ ({32'd0, x} << i);
      if (x[i]) ones++;
      if (lead == i && !x[31-i]) lead++;     // Zeros from the top
      if (trail == i && !x[i]) trail++;      // Zeros from the bottom
    end
    case (opSel)
      bitAluPkg::OpSub:    r = x - y;
      bitAluPkg::OpAnd:    r = x & y;
      bitAluPkg::OpOr:     r = x | y;
      bitAluPkg::OpXor:    r = x ^ y;
      bitAluPkg::OpSll:    r = x << sh;
      bitAluPkg::OpSrl:    r = x >> sh;
      bitAluPkg::OpSra:    r = $unsigned($signed(x) >>> sh);
      bitAluPkg::OpSlt:    r = {31'd0, $signed(x) < $signed(y)};
      bitAluPkg::OpSltu:   r = {31'd0, x < y};
      bitAluPkg::OpSh1Add: r = (x << 1) + y;
      bitAluPkg::OpSh2Add: r = (x << 2) + y;
      bitAluPkg::OpSh3Add: r = (x << 3) + y;
      bitAluPkg::OpBset:   r = x | (32'd1 << sh);
      bitAluPkg::OpBclr:   r = x & ~(32'd1 << sh);
      bitAluPkg::OpBinv:   r = x ^ (32'd1 << sh);
      bitAluPkg::OpBext:   r = {31'd0, x[sh]};
      bitAluPkg::OpAndn:   r = x & ~y;
      bitAluPkg::OpOrn:    r = x | ~y;
      bitAluPkg::OpXnor:   r = ~(x ^ y);
      bitAluPkg::OpClz:    r = lead;
      bitAluPkg::OpCtz:    r = trail;
      bitAluPkg::OpCpop:   r = ones;
      bitAluPkg::OpMax:    r = ($signed(x) < $signed(y)) ? y : x;
      bitAluPkg::OpMaxu:   r = (x < y) ? y : x;
      bitAluPkg::OpMin:    r = ($signed(x) < $signed(y)) ? x : y;
      bitAluPkg::OpMinu:   r = (x < y) ? x : y;
      bitAluPkg::OpSextb:  r = {{24{x[7]}}, x[7:0]};
      bitAluPkg::OpSexth:  r = {{16{x[15]}}, x[15:0]};
      bitAluPkg::OpZexth:  r = {16'd0, x[15:0]};
      bitAluPkg::OpRol:    r = (x << sh) | (x >> (32 - sh));  // Shift by 32 gives 0
      bitAluPkg::OpRor:    r = (x >> sh) | (x << (32 - sh));
      bitAluPkg::OpRev8:   r = {x[7:0], x[15:8], x[23:16], x[31:24]};
      bitAluPkg::OpOrcb: begin
        for (i = 0; i < 4; i++) begin
          r[8*i +: 8] = (x[8*i +: 8] != 8'd0) ? 8'hff : 8'h00;
        end
      end
      bitAluPkg::OpClmul:  r = prod[31:0];
      bitAluPkg::OpClmulh: r = prod[63:32];
      bitAluPkg::OpClmulr: r = prod[62:31];
      default:             r = x + y;      // ADD
    endcase
    return r;
  endfunction

  ////////////////////////////////////////////////////////////////////
  // Drive and check
  ////////////////////////////////////////////////////////////////////
  task automatic checkOutput(input logic [31:0] expected, input bitAluPkg::aluOp_e opSel);
    checkCount++;
    assert (resultValid === 1'b1) else begin
      errorCount++;
      $display("ERR t=%0t resultValid exp=1 got=%b op=%s", $time, resultValid, opSel.name());
    end
    assert (result === expected) else begin
      errorCount++;
      $display("ERR t=%0t result exp=%h got=%h op=%s", $time, expected, result,
               opSel.name());
    end
  endtask

  // One strobe and a check one cycle later
  task automatic applyOp(input bitAluPkg::aluOp_e opSel, input logic [31:0] x,
                         input logic [31:0] y);
    logic [31:0] expected;
    expected = refResult(opSel, x, y);
    @(posedge clk);
    #2;
    valid = 1'b1;
    op    = opSel;
    a     = x;
    b     = y;
    @(posedge clk);
    #2;
    valid = 1'b0;
    checkOutput(expected, opSel);
  endtask

  // All corner pairs followed by random pairs
  task automatic sweepOp(input bitAluPkg::aluOp_e opSel);
    int i;
    int j;
    for (i = 0; i < 4; i++) begin
      for (j = 0; j < 4; j++) begin
        applyOp(opSel, cornerValue(i), cornerValue(j));
      end
    end
    for (i = 0; i < RandPerOp; i++) begin
      applyOp(opSel, nextRandom(), nextRandom());
    end
  endtask

  // Sweep a run of consecutive op codes
  task automatic sweepRange(input bitAluPkg::aluOp_e first, input int count);
    bitAluPkg::aluOp_e opSel;
    opSel = first;
    repeat (count) begin
      sweepOp(opSel);
      opSel = opSel.next();
    end
  endtask

  task automatic baseAluSweep();
    sweepRange(bitAluPkg::OpAdd, 10);        // ADD .. SLTU
  endtask

  task automatic zbaZbsSweep();
    sweepRange(bitAluPkg::OpSh1Add, 7);      // SH1ADD .. BEXT
  endtask

  task automatic zbbSweep();
    sweepRange(bitAluPkg::OpAndn, 17);       // ANDN .. ORCB
  endtask

  task automatic clmulSweep();
    sweepRange(bitAluPkg::OpClmul, 3);
  endtask

  // Reset over a live strobe clears a non-zero result
  task automatic resetClearsOutputs();
    applyOp(bitAluPkg::OpOr, 32'h1234_5678, 32'h8000_0001);
    rst   = 1'b1;
    valid = 1'b1;                            // Strobe held through reset
    repeat (ResetCycles) @(posedge clk);
    #2;
    rst   = 1'b0;
    valid = 1'b0;
    assert (resultValid === 1'b0) else begin
      errorCount++;
      $display("ERR t=%0t resultValid exp=0 got=%b", $time, resultValid);
    end
    assert (result === 32'd0) else begin
      errorCount++;
      $display("ERR t=%0t result exp=%h got=%h", $time, 32'd0, result);
    end
  endtask

  // Back-to-back strobes with each result one cycle later
  task automatic burstTiming();
    logic [31:0]       expQ [$];
    logic [31:0]       lastExp;
    logic [31:0]       x;
    logic [31:0]       y;
    bitAluPkg::aluOp_e opSel;
    bitAluPkg::aluOp_e prevOp;
    int                n;
    opSel  = bitAluPkg::OpAdd;
    prevOp = opSel;
    @(posedge clk);
    for (n = 0; n < BurstLen; n++) begin
      x = nextRandom();
      y = nextRandom();
      #2;
      valid = 1'b1;
      op    = opSel;
      a     = x;
      b     = y;
      if (n > 0) checkOutput(expQ.pop_front(), prevOp);
      expQ.push_back(refResult(opSel, x, y));
      prevOp = opSel;
      opSel  = opSel.next();
      @(posedge clk);
    end
    #2;
    valid   = 1'b0;
    lastExp = expQ.pop_front();
    checkOutput(lastExp, prevOp);
    op = bitAluPkg::OpXor;                   // Idle operands give another value
    a  = lastExp;
    b  = 32'h0000_0001;
    @(posedge clk);
    #2;
    // Strobe drops and result holds on the idle cycle
    assert (resultValid === 1'b0) else begin
      errorCount++;
      $display("ERR t=%0t resultValid exp=0 got=%b", $time, resultValid);
    end
    assert (result === lastExp) else begin
      errorCount++;
      $display("ERR t=%0t result exp=%h got=%h", $time, lastExp, result);
    end
  endtask

  ////////////////////////////////////////////////////////////////////
  // Main sequence and watchdog
  ////////////////////////////////////////////////////////////////////
  initial begin
    rst   = 1'b1;
    valid = 1'b0;
    op    = bitAluPkg::OpAdd;
    a     = '0;
    b     = '0;
    repeat (ResetCycles) @(posedge clk);
    #2;
    rst = 1'b0;
    resetClearsOutputs();
    baseAluSweep();
    zbaZbsSweep();
    zbbSweep();
    clmulSweep();
    burstTiming();
    $display("Checks run: %0d, errors: %0d", checkCount, errorCount);
    if (errorCount == 0) begin
      $display("No errors");
    end else begin
      $display("Errors found");
    end
    $finish;
  end

  initial begin
    #(TimeoutNs);
    $display("Watchdog expired after %0d ns, test sequence did not complete", TimeoutNs);
    $display("Errors found");
    $finish;
  end

endmodule

`default_nettype wire

// ==== logic/aluCore.sv ====
//////////////////////////////////////////////////////////////////////
// Base integer ALU
// Shared adder, logic ops, barrel shifter and compare flags
//////////////////////////////////////////////////////////////////////
`timescale 1ns/1ns
`default_nettype none

module aluCore (
  input  logic [bitAluPkg::Xlen-1:0] condShiftA,
  input  logic [bitAluPkg::Xlen-1:0] condMaskB,
  input  logic [bitAluPkg::Xlen-1:0] b,
  input  bitAluPkg::coreFn_e         coreFn,
  input  logic                       subtract,
  input  logic                       invertB,
  input  logic                       shiftRight,
  input  logic                       shiftArith,
  input  logic                       extractBit,
  output logic [bitAluPkg::Xlen-1:0] coreResult,
  output logic                       lt,
  output logic                       ltu
);

  logic [bitAluPkg::Xlen-1:0]        addB;   // Adder B, inverted on subtract
  logic [bitAluPkg::Xlen:0]          sum;    // Carry out on top
  logic [bitAluPkg::Xlen-1:0]        logicB;
  logic [bitAluPkg::Xlen-1:0]        shIn;
  logic signed [bitAluPkg::Xlen:0]   shExt;  // Extra fill bit on top
  logic [bitAluPkg::Xlen-1:0]        shOut;
  logic [bitAluPkg::Xlen-1:0]        shRes;

  ////////////////////////////////////////////////////////////////////
  // Adder and flags
  ////////////////////////////////////////////////////////////////////
  assign addB = subtract ? ~condMaskB : condMaskB;
  assign sum  = {1'b0, condShiftA} + {1'b0, addB} + {{bitAluPkg::Xlen{1'b0}}, subtract};

  assign ltu = ~sum[bitAluPkg::Xlen];        // Borrow out
  // Signs differ so A's sign decides
  assign lt  = (condShiftA[bitAluPkg::Xlen-1] ^ condMaskB[bitAluPkg::Xlen-1]) ?
               condShiftA[bitAluPkg::Xlen-1] : sum[bitAluPkg::Xlen-1];

  assign logicB = invertB ? ~condMaskB : condMaskB;   // BCLR clears via ~mask

  ////////////////////////////////////////////////////////////////////
  // Shifter
  ////////////////////////////////////////////////////////////////////
  // Left shifts run right on the reversed word
  assign shIn  = shiftRight ? condShiftA : bitAluPkg::bitRev(condShiftA);
  assign shExt = $signed({shiftArith & condShiftA[bitAluPkg::Xlen-1], shIn}) >>>
                 b[bitAluPkg::ShamtW-1:0];
  assign shOut = shiftRight ? shExt[bitAluPkg::Xlen-1:0] :
                 bitAluPkg::bitRev(shExt[bitAluPkg::Xlen-1:0]);
  assign shRes = extractBit ? {{(bitAluPkg::Xlen-1){1'b0}}, shOut[0]} : shOut;  // BEXT

  always_comb begin
    case (coreFn)
      bitAluPkg::CoreAdd,
      bitAluPkg::CoreSub:   coreResult = sum[bitAluPkg::Xlen-1:0];
      bitAluPkg::CoreAnd:   coreResult = condShiftA & logicB;
      bitAluPkg::CoreOr:    coreResult = condShiftA | logicB;
      bitAluPkg::CoreXor:   coreResult = condShiftA ^ logicB;
      bitAluPkg::CoreShift: coreResult = shRes;
      bitAluPkg::CoreSlt:   coreResult = {{(bitAluPkg::Xlen-1){1'b0}}, lt};
      bitAluPkg::CoreSltu:  coreResult = {{(bitAluPkg::Xlen-1){1'b0}}, ltu};
      default:              coreResult = sum[bitAluPkg::Xlen-1:0];
    endcase
  end

endmodule

`default_nettype wire

// ==== logic/aluDecoder.sv ====
//////////////////////////////////////////////////////////////////////
// Execute stage decoder
// Operation code to base ALU and bit-manipulation selects
//////////////////////////////////////////////////////////////////////
`timescale 1ns/1ns
`default_nettype none

module aluDecoder (
  input  bitAluPkg::aluOp_e     op,
  output bitAluPkg::coreFn_e    coreFn,
  output logic                  subtract,
  output logic                  invertB,
  output logic                  shiftRight,
  output logic                  shiftArith,
  output logic                  extractBit,
  output bitAluPkg::resultSel_e resultSel,
  output bitAluPkg::zbbFn_e     zbbFn,
  output bitAluPkg::clmulFn_e   clmulFn,
  output logic                  bmuActive,
  output logic                  preShift,
  output logic [1:0]            preShiftAmt,
  output logic                  maskB
);

  logic [5:0] zbbIdx;                        // Offset into the Zbb run
  logic [5:0] clmulIdx;                      // Offset into the Zbc run

  assign zbbIdx   = op - bitAluPkg::OpAndn;
  assign clmulIdx = op - bitAluPkg::OpClmul;

  always_comb begin
    // Defaults give a plain ADD
    coreFn      = bitAluPkg::CoreAdd;
    subtract    = 1'b0;
    invertB     = 1'b0;
    shiftRight  = 1'b0;
    shiftArith  = 1'b0;
    extractBit  = 1'b0;
    resultSel   = bitAluPkg::SelCore;
    zbbFn       = bitAluPkg::ZbbAndn;
    clmulFn     = bitAluPkg::ClmulLow;
    bmuActive   = 1'b0;
    preShift    = 1'b0;
    preShiftAmt = 2'd0;
    maskB       = 1'b0;
    case (op)
      bitAluPkg::OpSub: begin
        coreFn   = bitAluPkg::CoreSub;
        subtract = 1'b1;
      end
      bitAluPkg::OpAnd: coreFn = bitAluPkg::CoreAnd;
      bitAluPkg::OpOr:  coreFn = bitAluPkg::CoreOr;
      bitAluPkg::OpXor: coreFn = bitAluPkg::CoreXor;
      bitAluPkg::OpSll: coreFn = bitAluPkg::CoreShift;
      bitAluPkg::OpSrl: begin
        coreFn     = bitAluPkg::CoreShift;
        shiftRight = 1'b1;
      end
      bitAluPkg::OpSra: begin
        coreFn     = bitAluPkg::CoreShift;
        shiftRight = 1'b1;
        shiftArith = 1'b1;                   // Sign fill
      end
      bitAluPkg::OpSlt: begin
        coreFn   = bitAluPkg::CoreSlt;
        subtract = 1'b1;
      end
      bitAluPkg::OpSltu: begin
        coreFn   = bitAluPkg::CoreSltu;
        subtract = 1'b1;
      end
      // Zba shift-add on the pre-shifted A
      bitAluPkg::OpSh1Add: begin
        preShift    = 1'b1;
        preShiftAmt = 2'd1;
      end
      bitAluPkg::OpSh2Add: begin
        preShift    = 1'b1;
        preShiftAmt = 2'd2;
      end
      bitAluPkg::OpSh3Add: begin
        preShift    = 1'b1;
        preShiftAmt = 2'd3;
      end
      // Zbs through the core logic ops on the one-hot mask
      bitAluPkg::OpBset: begin
        coreFn = bitAluPkg::CoreOr;
        maskB  = 1'b1;
      end
      bitAluPkg::OpBclr: begin
        coreFn  = bitAluPkg::CoreAnd;
        maskB   = 1'b1;
        invertB = 1'b1;                      // AND with ~mask
      end
      bitAluPkg::OpBinv: begin
        coreFn = bitAluPkg::CoreXor;
        maskB  = 1'b1;
      end
      bitAluPkg::OpBext: begin
        coreFn     = bitAluPkg::CoreShift;
        shiftRight = 1'b1;
        extractBit = 1'b1;                   // Keep bit 0 only
      end
      bitAluPkg::OpAndn, bitAluPkg::OpOrn, bitAluPkg::OpXnor, bitAluPkg::OpClz,
      bitAluPkg::OpCtz, bitAluPkg::OpCpop, bitAluPkg::OpMax, bitAluPkg::OpMaxu,
      bitAluPkg::OpMin, bitAluPkg::OpMinu, bitAluPkg::OpSextb, bitAluPkg::OpSexth,
      bitAluPkg::OpZexth, bitAluPkg::OpRol, bitAluPkg::OpRor, bitAluPkg::OpRev8,
      bitAluPkg::OpOrcb: begin
        bmuActive = 1'b1;
        resultSel = bitAluPkg::SelZbb;
        zbbFn     = bitAluPkg::zbbFn_e'(zbbIdx[4:0]);
        subtract  = 1'b1;                    // Min/max read the core compare
      end
      bitAluPkg::OpClmul, bitAluPkg::OpClmulh, bitAluPkg::OpClmulr: begin
        bmuActive = 1'b1;
        resultSel = bitAluPkg::SelClmul;
        clmulFn   = bitAluPkg::clmulFn_e'(clmulIdx[1:0]);
      end
      default: ;                             // Unknown codes act as ADD
    endcase
  end

endmodule

`default_nettype wire

// ==== logic/bitAluPkg.sv ====
//////////////////////////////////////////////////////////////////////
// Bit-manipulation ALU package
// Word width, operation codes and the datapath select encodings
//////////////////////////////////////////////////////////////////////
`default_nettype none

package bitAluPkg;

  localparam int Xlen   = 32;                // RV32 word
  localparam int ShamtW = 5;                 // log2 of Xlen

  // Operation codes
  // Zbb and Zbc runs keep the order of zbbFn_e and clmulFn_e
  typedef enum logic [5:0] {
    OpAdd, OpSub, OpAnd, OpOr, OpXor, OpSll, OpSrl, OpSra, OpSlt, OpSltu,
    OpSh1Add, OpSh2Add, OpSh3Add,                          // Zba
    OpBset, OpBclr, OpBinv, OpBext,                        // Zbs
    OpAndn, OpOrn, OpXnor, OpClz, OpCtz, OpCpop,           // Zbb
    OpMax, OpMaxu, OpMin, OpMinu, OpSextb, OpSexth, OpZexth,
    OpRol, OpRor, OpRev8, OpOrcb,
    OpClmul, OpClmulh, OpClmulr                            // Zbc
  } aluOp_e;

  typedef enum logic [2:0] {
    CoreAdd, CoreSub, CoreAnd, CoreOr, CoreXor, CoreShift, CoreSlt, CoreSltu
  } coreFn_e;

  typedef enum logic [1:0] {SelCore, SelZbb, SelClmul} resultSel_e;

  // 17 Zbb functions so one bit more than a nibble
  typedef enum logic [4:0] {
    ZbbAndn, ZbbOrn, ZbbXnor, ZbbClz, ZbbCtz, ZbbCpop,
    ZbbMax, ZbbMaxu, ZbbMin, ZbbMinu, ZbbSextb, ZbbSexth, ZbbZexth,
    ZbbRol, ZbbRor, ZbbRev8, ZbbOrcb
  } zbbFn_e;

  typedef enum logic [1:0] {ClmulLow, ClmulHigh, ClmulRev} clmulFn_e;

  // Bit reverse of a word
  function automatic logic [Xlen-1:0] bitRev(input logic [Xlen-1:0] x);
    logic [Xlen-1:0] r;
    for (int i = 0; i < Xlen; i++) begin
      r[i] = x[Xlen-1-i];
    end
    return r;
  endfunction

endpackage

`default_nettype wire

// ==== logic/bitManipAlu.sv ====
//////////////////////////////////////////////////////////////////////
// Bit-manipulation unit
// Operand gating, Zba pre-shift, Zbs mask and final result select
//////////////////////////////////////////////////////////////////////
`timescale 1ns/1ns
`default_nettype none

module bitManipAlu (
  input  logic [bitAluPkg::Xlen-1:0] a,
  input  logic [bitAluPkg::Xlen-1:0] b,
  input  logic                       bmuActive,
  input  logic                       preShift,
  input  logic [1:0]                 preShiftAmt,
  input  logic                       maskB,
  input  bitAluPkg::zbbFn_e          zbbFn,
  input  bitAluPkg::clmulFn_e        clmulFn,
  input  bitAluPkg::resultSel_e      resultSel,
  input  logic                       lt,
  input  logic                       ltu,
  input  logic [bitAluPkg::Xlen-1:0] coreResult,
  output logic [bitAluPkg::Xlen-1:0] condShiftA,
  output logic [bitAluPkg::Xlen-1:0] condMaskB,
  output logic [bitAluPkg::Xlen-1:0] result
);

  logic [bitAluPkg::Xlen-1:0] aBmu, bBmu;    // Gated operands
  logic [bitAluPkg::Xlen-1:0] maskOneHot;
  logic [bitAluPkg::Xlen-1:0] revA;          // Shared by CTZ and Zbc
  logic [bitAluPkg::Xlen-1:0] zbbResult;
  logic [bitAluPkg::Xlen-1:0] clmulResult;

  // Hold Zbb/Zbc inputs at zero during base ops
  assign aBmu = a & {bitAluPkg::Xlen{bmuActive}};
  assign bBmu = b & {bitAluPkg::Xlen{bmuActive}};

  assign condShiftA = a << ({2{preShift}} & preShiftAmt);  // sh1add..sh3add

  // One-hot bit select for Zbs
  assign maskOneHot = {{(bitAluPkg::Xlen-1){1'b0}}, 1'b1} << b[bitAluPkg::ShamtW-1:0];
  assign condMaskB  = maskB ? maskOneHot : b;

  assign revA = bitAluPkg::bitRev(aBmu);

  zbbUnit i_zbb (
    .a(aBmu),
    .revA,
    .b(bBmu),
    .lt,
    .ltu,
    .zbbFn,
    .zbbResult
  );

  clmulUnit i_clmul (
    .a(aBmu),
    .revA,
    .b(bBmu),
    .clmulFn,
    .clmulResult
  );

  always_comb begin
    case (resultSel)
      bitAluPkg::SelCore:  result = coreResult;       // Base, Zba, Zbs
      bitAluPkg::SelZbb:   result = zbbResult;
      bitAluPkg::SelClmul: result = clmulResult;
      default:             result = coreResult;
    endcase
  end

endmodule

`default_nettype wire

// ==== logic/clmulUnit.sv ====
//////////////////////////////////////////////////////////////////////
// Zbc carry-less multiply
// One XOR array for the low, high and reversed products
//////////////////////////////////////////////////////////////////////
`timescale 1ns/1ns
`default_nettype none

module clmulUnit (
  input  logic [bitAluPkg::Xlen-1:0] a,
  input  logic [bitAluPkg::Xlen-1:0] revA,
  input  logic [bitAluPkg::Xlen-1:0] b,
  input  bitAluPkg::clmulFn_e        clmulFn,
  output logic [bitAluPkg::Xlen-1:0] clmulResult
);

  logic [bitAluPkg::Xlen-1:0] x, y;          // Array operands
  logic [bitAluPkg::Xlen-1:0] prod;          // Low word of x clmul y
  logic [bitAluPkg::Xlen-1:0] revProd;

  // High and reversed forms run on reversed operands
  assign x = (clmulFn == bitAluPkg::ClmulLow) ? a : revA;
  assign y = (clmulFn == bitAluPkg::ClmulLow) ? b : bitAluPkg::bitRev(b);

  always_comb begin
    prod = '0;
    for (int i = 0; i < bitAluPkg::Xlen; i++) begin
      if (y[i]) prod = prod ^ (x << i);
    end
  end

  assign revProd = bitAluPkg::bitRev(prod);  // clmulr

  always_comb begin
    case (clmulFn)
      bitAluPkg::ClmulLow:  clmulResult = prod;
      bitAluPkg::ClmulHigh: clmulResult = revProd >> 1;   // clmulh is clmulr >> 1
      bitAluPkg::ClmulRev:  clmulResult = revProd;
      default:              clmulResult = prod;
    endcase
  end

endmodule

`default_nettype wire

// ==== logic/executeStage.sv ====
//////////////////////////////////////////////////////////////////////
// RV32 integer execute stage with Zba/Zbb/Zbc/Zbs
// Decoder, base ALU and bit-manipulation unit behind one output register
//////////////////////////////////////////////////////////////////////
`timescale 1ns/1ns
`default_nettype none

module executeStage (
  input  logic                       clk,
  input  logic                       rst,
  input  logic                       valid,  // One-cycle strobe
  input  bitAluPkg::aluOp_e          op,
  input  logic [bitAluPkg::Xlen-1:0] a,
  input  logic [bitAluPkg::Xlen-1:0] b,
  output logic [bitAluPkg::Xlen-1:0] result,
  output logic                       resultValid
);

  bitAluPkg::coreFn_e         coreFn;
  logic                       subtract, invertB, shiftRight, shiftArith, extractBit;
  bitAluPkg::resultSel_e      resultSel;
  bitAluPkg::zbbFn_e          zbbFn;
  bitAluPkg::clmulFn_e        clmulFn;
  logic                       bmuActive, preShift, maskB;
  logic [1:0]                 preShiftAmt;
  logic [bitAluPkg::Xlen-1:0] condShiftA, condMaskB, coreResult;
  logic                       lt, ltu;
  logic [bitAluPkg::Xlen-1:0] aluResult;     // Unregistered result

  aluDecoder i_decoder (
    .op, .coreFn, .subtract, .invertB, .shiftRight, .shiftArith, .extractBit,
    .resultSel, .zbbFn, .clmulFn, .bmuActive, .preShift, .preShiftAmt, .maskB
  );

  aluCore i_core (
    .condShiftA, .condMaskB, .b, .coreFn, .subtract, .invertB, .shiftRight,
    .shiftArith, .extractBit, .coreResult, .lt, .ltu
  );

  bitManipAlu i_bmu (
    .a, .b, .bmuActive, .preShift, .preShiftAmt, .maskB, .zbbFn, .clmulFn,
    .resultSel, .lt, .ltu, .coreResult, .condShiftA, .condMaskB, .result(aluResult)
  );

  // One cycle latency, result holds when idle
  always_ff @(posedge clk) begin
    if (rst) begin
      result      <= '0;
      resultValid <= 1'b0;
    end else begin
      resultValid <= valid;
      if (valid) begin
        result <= aluResult;
      end
    end
  end

endmodule

`default_nettype wire

// ==== logic/zbbUnit.sv ====
//////////////////////////////////////////////////////////////////////
// Zbb basic bit-manipulation unit
// Counts, min/max, extends, rotates, byte ops and inverted logic
//////////////////////////////////////////////////////////////////////
`timescale 1ns/1ns
`default_nettype none

module zbbUnit (
  input  logic [bitAluPkg::Xlen-1:0] a,
  input  logic [bitAluPkg::Xlen-1:0] revA,
  input  logic [bitAluPkg::Xlen-1:0] b,
  input  logic                       lt,
  input  logic                       ltu,
  input  bitAluPkg::zbbFn_e          zbbFn,
  output logic [bitAluPkg::Xlen-1:0] zbbResult
);

  logic [bitAluPkg::Xlen-1:0]   cntIn;       // Counter input a or revA
  logic [bitAluPkg::ShamtW:0]   lzc;         // 0..Xlen
  logic [bitAluPkg::ShamtW:0]   pop;
  logic [2*bitAluPkg::Xlen-1:0] rolFull, rorFull;
  logic [bitAluPkg::Xlen-1:0]   rev8Res, orcbRes;

  // CTZ is CLZ of the reversed word
  assign cntIn = (zbbFn == bitAluPkg::ZbbCtz) ? revA : a;

  // Leading zeros set by the highest set bit
  always_comb begin
    lzc = (bitAluPkg::ShamtW+1)'(bitAluPkg::Xlen);
    for (int i = 0; i < bitAluPkg::Xlen; i++) begin
      if (cntIn[i]) lzc = (bitAluPkg::ShamtW+1)'(bitAluPkg::Xlen-1-i);
    end
  end

  always_comb begin
    pop = '0;
    for (int i = 0; i < bitAluPkg::Xlen; i++) begin
      pop = pop + {{bitAluPkg::ShamtW{1'b0}}, a[i]};  // Population count
    end
  end

  // Rotates on the doubled word
  assign rolFull = {a, a} << b[bitAluPkg::ShamtW-1:0];
  assign rorFull = {a, a} >> b[bitAluPkg::ShamtW-1:0];

  always_comb begin
    for (int i = 0; i < bitAluPkg::Xlen/8; i++) begin
      rev8Res[8*i +: 8] = a[bitAluPkg::Xlen-8-8*i +: 8];
      orcbRes[8*i +: 8] = {8{|a[8*i +: 8]}};  // Any bit set fills byte
    end
  end

  always_comb begin
    case (zbbFn)
      bitAluPkg::ZbbAndn:  zbbResult = a & ~b;
      bitAluPkg::ZbbOrn:   zbbResult = a | ~b;
      bitAluPkg::ZbbXnor:  zbbResult = ~(a ^ b);
      bitAluPkg::ZbbClz,
      bitAluPkg::ZbbCtz:   zbbResult = {{(bitAluPkg::Xlen-bitAluPkg::ShamtW-1){1'b0}}, lzc};
      bitAluPkg::ZbbCpop:  zbbResult = {{(bitAluPkg::Xlen-bitAluPkg::ShamtW-1){1'b0}}, pop};
      bitAluPkg::ZbbMax:   zbbResult = lt  ? b : a;
      bitAluPkg::ZbbMaxu:  zbbResult = ltu ? b : a;
      bitAluPkg::ZbbMin:   zbbResult = lt  ? a : b;
      bitAluPkg::ZbbMinu:  zbbResult = ltu ? a : b;
      bitAluPkg::ZbbSextb: zbbResult = {{(bitAluPkg::Xlen-8){a[7]}}, a[7:0]};
      bitAluPkg::ZbbSexth: zbbResult = {{(bitAluPkg::Xlen-16){a[15]}}, a[15:0]};
      bitAluPkg::ZbbZexth: zbbResult = {{(bitAluPkg::Xlen-16){1'b0}}, a[15:0]};
      bitAluPkg::ZbbRol:   zbbResult = rolFull[2*bitAluPkg::Xlen-1:bitAluPkg::Xlen];
      bitAluPkg::ZbbRor:   zbbResult = rorFull[bitAluPkg::Xlen-1:0];
      bitAluPkg::ZbbRev8:  zbbResult = rev8Res;
      bitAluPkg::ZbbOrcb:  zbbResult = orcbRes;
      default:             zbbResult = '0;
    endcase
  end

endmodule

`default_nettype wire
